// File: src/icache_defines.svh
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// Geometry
`define ICACHE_ADDR_WIDTH 32
`define ICACHE_LINE_WIDTH 128
`define ICACHE_NSET 64
`define ICACHE_NWAY 2

// Address split, tag | index | byte offset
`define ICACHE_OFFSET_WIDTH 4
`define ICACHE_INDEX_WIDTH 6
`define ICACHE_TAG_WIDTH 22

`endif

// File: src/icache_pkg.sv
`include "icache_defines.svh"

package icache_pkg;

    typedef logic [`ICACHE_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`ICACHE_LINE_WIDTH-1:0] line_t;
    typedef logic [`ICACHE_INDEX_WIDTH-1:0] index_t;
    typedef logic [`ICACHE_TAG_WIDTH-1:0] tag_t;
    typedef logic [`ICACHE_NWAY-1:0] way_sel_t;

    // One tag RAM word
    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    // RAM access broadcast to every way
    typedef struct packed {
        logic       en;
        logic       we;
        index_t     index;
        tag_entry_t entry;
        line_t      line;
    } way_req_t;

    typedef enum logic [1:0] {
        IDLE,
        REFILL_REQ,
        REFILL_WAIT,
        INVALIDATE
    } ctrl_state_e;

endpackage

// File: src/icache_sram.sv
`timescale 1ns/10ps

module icache_sram #(
    parameter int DATA_WIDTH = 32,
    parameter int DEPTH      = 64
) (
    input  logic                     clk,
    input  logic                     en_i,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] addr_i,
    input  logic [DATA_WIDTH-1:0]    wdata_i,
    output logic [DATA_WIDTH-1:0]    rdata_o
);

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    // Write or read, never both
    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                mem[addr_i] <= wdata_i;
            end else begin
                rdata_o <= mem[addr_i];
            end
        end
    end

endmodule

// File: src/icache_lfsr.sv
`timescale 1ns/10ps

module icache_lfsr (
    input  logic        clk,
    input  logic        rst,
    output logic [15:0] value_o
);

    logic [15:0] state;
    logic        feedback;

    // Taps 16 14 13 11, maximal length
    assign feedback = state[15] ^ state[13] ^ state[12] ^ state[10];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= 16'hace1;
        end else begin
            state <= {state[14:0], feedback};
        end
    end

    assign value_o = state;

endmodule

// File: src/icache_way.sv
`timescale 1ns/10ps
`include "icache_defines.svh"

module icache_way
    import icache_pkg::*;
(
    input  logic     clk,
    input  way_req_t req_i,
    input  logic     wsel_i,
    input  tag_t     lookup_tag_i,
    output logic     hit_o,
    output line_t    line_o
);

    logic       we;
    tag_entry_t tag_rdata;

    // Writes land only in the selected way
    assign we = req_i.we & wsel_i;

    icache_sram #(
        .DATA_WIDTH($bits(tag_entry_t)),
        .DEPTH     (`ICACHE_NSET)
    ) u_tag_ram (
        .clk    (clk),
        .en_i   (req_i.en),
        .we_i   (we),
        .addr_i (req_i.index),
        .wdata_i(req_i.entry),
        .rdata_o(tag_rdata)
    );

    icache_sram #(
        .DATA_WIDTH(`ICACHE_LINE_WIDTH),
        .DEPTH     (`ICACHE_NSET)
    ) u_data_ram (
        .clk    (clk),
        .en_i   (req_i.en),
        .we_i   (we),
        .addr_i (req_i.index),
        .wdata_i(req_i.line),
        .rdata_o(line_o)
    );

    assign hit_o = tag_rdata.valid && (tag_rdata.tag == lookup_tag_i);

endmodule

// File: src/icache_ctrl.sv
`timescale 1ns/10ps
`include "icache_defines.svh"

module icache_ctrl
    import icache_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         rreq_i,
    input  logic                         rreq_uncached_i,
    input  addr_t                        raddr_i,
    output logic                         rreq_ack_o,
    output logic                         rvalid_o,
    output line_t                        rdata_o,
    input  logic                         invalidate_i,
    output logic                         mem_req_o,
    output addr_t                        mem_addr_o,
    input  logic                         mem_ready_i,
    input  logic                         mem_rvalid_i,
    input  line_t                        mem_rdata_i,
    input  logic [15:0]                  random_i,
    input  way_sel_t                     way_hit_i,
    input  line_t [`ICACHE_NWAY-1:0]     way_line_i,
    output way_req_t                     way_req_o,
    output way_sel_t                     way_wsel_o,
    output tag_t                         lookup_tag_o
);

    localparam int WAY_BITS = (`ICACHE_NWAY > 1) ? $clog2(`ICACHE_NWAY) : 1;

    ctrl_state_e state, next_state;

    logic   accept;
    logic   miss;
    logic   hit;
    logic   refill_done;
    logic   inval_pend;
    logic   inval_req;
    logic   sweep_done;
    index_t sweep_cnt;

    logic   s1_valid;
    logic   s1_uncached;
    addr_t  s1_addr;
    index_t s1_index;
    index_t raddr_index;

    assign raddr_index  = raddr_i[`ICACHE_OFFSET_WIDTH +: `ICACHE_INDEX_WIDTH];
    assign s1_index     = s1_addr[`ICACHE_OFFSET_WIDTH +: `ICACHE_INDEX_WIDTH];
    assign lookup_tag_o = s1_addr[`ICACHE_ADDR_WIDTH-1 -: `ICACHE_TAG_WIDTH];

    ////////////////////
    // Control

    assign hit  = (state == IDLE) && s1_valid && !s1_uncached && (|way_hit_i);
    assign miss = (state == IDLE) && s1_valid && (s1_uncached || !(|way_hit_i));

    // Invalidate held over a miss so it is not lost
    assign inval_req = invalidate_i | inval_pend;

    assign rreq_ack_o  = (state == IDLE) && !miss && !inval_req;
    assign accept      = rreq_i & rreq_ack_o;
    assign refill_done = (state == REFILL_WAIT) && mem_rvalid_i;
    assign sweep_done  = sweep_cnt == index_t'(`ICACHE_NSET - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= INVALIDATE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (miss) begin
                    next_state = REFILL_REQ;
                end else if (inval_req) begin
                    next_state = INVALIDATE;
                end
            end
            REFILL_REQ: begin
                if (mem_ready_i) next_state = REFILL_WAIT;
            end
            REFILL_WAIT: begin
                if (mem_rvalid_i) next_state = IDLE;
            end
            INVALIDATE: begin
                if (sweep_done) next_state = IDLE;
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            inval_pend <= 1'b0;
        end else if (state == INVALIDATE) begin
            inval_pend <= 1'b0;
        end else if (state == IDLE && invalidate_i) begin
            inval_pend <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || state != INVALIDATE) begin
            sweep_cnt <= '0;
        end else begin
            sweep_cnt <= sweep_cnt + index_t'(1);
        end
    end

    ////////////////////
    // Stage 1

    // Held through a miss until the refill returns
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else if (state == IDLE && !miss) begin
            s1_valid <= accept;
        end else if (refill_done) begin
            s1_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1_addr     <= raddr_i;
            s1_uncached <= rreq_uncached_i;
        end
    end

    ////////////////////
    // RAM access

    always_comb begin
        way_req_o  = '0;
        way_wsel_o = '0;
        case (state)
            IDLE: begin
                way_req_o.en    = accept;
                way_req_o.index = raddr_index;
            end
            REFILL_REQ, REFILL_WAIT: begin
                way_req_o.index = s1_index;
                if (refill_done && !s1_uncached) begin
                    way_req_o.en          = 1'b1;
                    way_req_o.we          = 1'b1;
                    way_req_o.entry.valid = 1'b1;
                    way_req_o.entry.tag   = lookup_tag_o;
                    way_req_o.line        = mem_rdata_i;
                    // Victim from the LFSR
                    way_wsel_o = way_sel_t'(1) << random_i[WAY_BITS-1:0];
                end
            end
            INVALIDATE: begin
                way_req_o.en    = 1'b1;
                way_req_o.we    = 1'b1;
                way_req_o.index = sweep_cnt;
                way_wsel_o      = '1;
            end
            default: ;
        endcase
    end

    ////////////////////
    // Memory side and read return

    assign mem_req_o  = state == REFILL_REQ;
    assign mem_addr_o = {s1_addr[`ICACHE_ADDR_WIDTH-1:`ICACHE_OFFSET_WIDTH],
                         {`ICACHE_OFFSET_WIDTH{1'b0}}};

    assign rvalid_o = hit | refill_done;

    always_comb begin
        rdata_o = mem_rdata_i;
        if (state == IDLE) begin
            for (int i = 0; i < `ICACHE_NWAY; i++) begin
                if (way_hit_i[i]) rdata_o = way_line_i[i];
            end
        end
    end

endmodule

// File: src/icache.sv
`timescale 1ns/10ps
`include "icache_defines.svh"

module icache
    import icache_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  rreq_i,
    input  logic  rreq_uncached_i,
    input  addr_t raddr_i,
    output logic  rreq_ack_o,
    output logic  rvalid_o,
    output line_t rdata_o,
    input  logic  invalidate_i,
    output logic  mem_req_o,
    output addr_t mem_addr_o,
    input  logic  mem_ready_i,
    input  logic  mem_rvalid_i,
    input  line_t mem_rdata_i
);

    logic [15:0]                 random;
    way_req_t                    way_req;
    way_sel_t                    way_wsel;
    way_sel_t                    way_hit;
    line_t [`ICACHE_NWAY-1:0]    way_line;
    tag_t                        lookup_tag;

    icache_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .rreq_i         (rreq_i),
        .rreq_uncached_i(rreq_uncached_i),
        .raddr_i        (raddr_i),
        .rreq_ack_o     (rreq_ack_o),
        .rvalid_o       (rvalid_o),
        .rdata_o        (rdata_o),
        .invalidate_i   (invalidate_i),
        .mem_req_o      (mem_req_o),
        .mem_addr_o     (mem_addr_o),
        .mem_ready_i    (mem_ready_i),
        .mem_rvalid_i   (mem_rvalid_i),
        .mem_rdata_i    (mem_rdata_i),
        .random_i       (random),
        .way_hit_i      (way_hit),
        .way_line_i     (way_line),
        .way_req_o      (way_req),
        .way_wsel_o     (way_wsel),
        .lookup_tag_o   (lookup_tag)
    );

    icache_lfsr u_lfsr (
        .clk    (clk),
        .rst    (rst),
        .value_o(random)
    );

    for (genvar i = 0; i < `ICACHE_NWAY; i++) begin : g_way
        icache_way u_way (
            .clk         (clk),
            .req_i       (way_req),
            .wsel_i      (way_wsel[i]),
            .lookup_tag_i(lookup_tag),
            .hit_o       (way_hit[i]),
            .line_o      (way_line[i])
        );
    end

endmodule

// File: dv/icache_checker.sv
`timescale 1ns/10ps

module icache_checker (
    input logic clk,
    input logic rst,
    input logic rreq_i,
    input logic rreq_ack_i,
    input logic rvalid_i,
    input logic mem_req_i,
    input logic mem_ready_i,
    input logic mem_rvalid_i
);

    int   fail_count = 0;
    logic accept;
    logic ready_seen;

    assign accept = rreq_i && rreq_ack_i;

    // Set by the ready strobe, cleared by the data beat
    always_ff @(posedge clk) begin
        if (rst) begin
            ready_seen <= 1'b0;
        end else if (mem_ready_i) begin
            ready_seen <= 1'b1;
        end else if (mem_rvalid_i) begin
            ready_seen <= 1'b0;
        end
    end

    req_held: assert property (@(posedge clk) disable iff (rst)
        mem_req_i && !mem_ready_i |=> mem_req_i)
        else begin
            $error("mem_req_o dropped before mem_ready_i");
            fail_count++;
        end

    // A lone accept cannot be answered in its own cycle
    no_same_cycle_data: assert property (@(posedge clk) disable iff (rst)
        accept && !$past(accept) |-> !rvalid_i)
        else begin
            $error("rvalid_o raised in the cycle of an accept");
            fail_count++;
        end

    no_ack_during_req: assert property (@(posedge clk) disable iff (rst)
        mem_req_i |-> !rreq_ack_i)
        else begin
            $error("rreq_ack_o high while mem_req_o is high");
            fail_count++;
        end

    data_after_ready: assert property (@(posedge clk) disable iff (rst)
        mem_rvalid_i |-> ready_seen)
        else begin
            $error("mem_rvalid_i without an earlier mem_ready_i");
            fail_count++;
        end

endmodule

bind icache icache_checker u_checker (
    .clk         (clk),
    .rst         (rst),
    .rreq_i      (rreq_i),
    .rreq_ack_i  (rreq_ack_o),
    .rvalid_i    (rvalid_o),
    .mem_req_i   (mem_req_o),
    .mem_ready_i (mem_ready_i),
    .mem_rvalid_i(mem_rvalid_i)
);

// File: dv/icache_tb.sv
`timescale 1ns/10ps
`include "icache_defines.svh"

module icache_tb
    import icache_pkg::*;
();

    localparam int B2B_LINES      = 4;
    localparam int RANDOM_READS   = 48;
    localparam int NUM_READS      = 1 + 2 + 3 + 3 + 2 * B2B_LINES + RANDOM_READS;
    localparam int TIMEOUT_CYCLES = NUM_READS * 20 + 2 * `ICACHE_NSET + 8;

    logic  clk;
    logic  rst;
    logic  rreq_i;
    logic  rreq_uncached_i;
    addr_t raddr_i;
    logic  rreq_ack_o;
    logic  rvalid_o;
    line_t rdata_o;
    logic  invalidate_i;
    logic  mem_req_o;
    addr_t mem_addr_o;
    logic  mem_ready_i;
    logic  mem_rvalid_i;
    line_t mem_rdata_i;

    addr_t       pending[$];
    int          accept_cycles[$];
    int          cycle = 0;
    int          mem_requests = 0;
    int          slow_results = 0;
    string       test_name = "reset";
    logic [31:0] stim_rng = 32'd70738;
    logic [31:0] mem_rng = 32'd70738;

    icache dut (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Expected line, built from the line address only
    function automatic line_t line_of(input addr_t addr);
        line_t       line;
        logic [31:0] base;
        base = (addr >> `ICACHE_OFFSET_WIDTH) * 32'h9e37_79b1;
        for (int i = 0; i < `ICACHE_LINE_WIDTH / 32; i++) begin
            line[i*32 +: 32] = base ^ (32'h0101_0101 * (i + 1));
        end
        return line;
    endfunction

    task automatic end_with_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_value(input string label, input line_t expected, input line_t actual);
        if (expected !== actual) begin
            $display("Fail %s (%s): expected %0h, actual %0h", test_name, label, expected,
                     actual);
            end_with_failure();
        end
    endtask

    // Holds the request until the DUT takes it
    task automatic issue_read(input addr_t addr, input logic uncached, output int waited);
        waited = 0;
        rreq_i = 1'b1;
        raddr_i = addr;
        rreq_uncached_i = uncached;
        @(negedge clk);
        while (!rreq_ack_o) begin
            waited++;
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        rreq_i = 1'b0;
    endtask

    task automatic drain();
        @(posedge clk);
        while (pending.size() != 0) @(posedge clk);
        #1;
    endtask

    ////////////////////
    // Response compare

    always @(negedge clk) begin : monitor
        addr_t addr;
        int    accepted_at;
        if (!rst) begin
            cycle++;
            if (rvalid_o) begin
                if (pending.size() == 0) begin
                    $display("rvalid_o pulsed with no read outstanding");
                    end_with_failure();
                end else begin
                    addr = pending.pop_front();
                    accepted_at = accept_cycles.pop_front();
                    check_value("read data", line_of(addr), rdata_o);
                    if (cycle - accepted_at != 1) slow_results++;
                end
            end
            if (rreq_i && rreq_ack_o) begin
                pending.push_back(raddr_i);
                accept_cycles.push_back(cycle);
            end
        end
    end

    ////////////////////
    // Memory model

    initial begin : memory_model
        addr_t addr;
        addr_t line_addr;
        int    delay;
        forever begin
            @(negedge clk);
            if (!rst && mem_req_o) begin
                // The oldest outstanding read is the one that missed
                if (pending.size() == 0) begin
                    $display("mem_req_o raised with no read outstanding");
                    end_with_failure();
                end else begin
                    line_addr = (pending[0] >> `ICACHE_OFFSET_WIDTH) << `ICACHE_OFFSET_WIDTH;
                    check_value("memory line address", line_addr, mem_addr_o);
                end
                addr = mem_addr_o;
                mem_requests++;
                mem_rng = xorshift(mem_rng);
                delay = 1 + mem_rng[1:0];
                repeat (delay) @(posedge clk);
                #1 mem_ready_i = 1'b1;
                @(posedge clk);
                #1 mem_ready_i = 1'b0;
                mem_rng = xorshift(mem_rng);
                delay = mem_rng[1:0];
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                mem_rvalid_i = 1'b1;
                mem_rdata_i = line_of(addr);
                @(posedge clk);
                #1 mem_rvalid_i = 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, reads were not answered", TIMEOUT_CYCLES);
        end_with_failure();
    end

    ////////////////////
    // Stimulus

    initial begin : stimulus
        int    waited;
        int    total_wait;
        int    base;
        addr_t addr;
        logic  uncached;
        clk = 1'b0;
        rst = 1'b1;
        rreq_i = 1'b0;
        rreq_uncached_i = 1'b0;
        raddr_i = '0;
        invalidate_i = 1'b0;
        mem_ready_i = 1'b0;
        mem_rvalid_i = 1'b0;
        mem_rdata_i = '0;
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;

        test_name = "reset_sweep";
        check_value("ack after reset", 0, rreq_ack_o);
        check_value("rvalid after reset", 0, rvalid_o);
        check_value("mem_req after reset", 0, mem_req_o);
        issue_read(32'h0000_1000, 1'b0, waited);
        check_value("ack held low for the sweep", 1, waited >= `ICACHE_NSET);
        drain();

        test_name = "hit_after_fill";
        base = mem_requests;
        issue_read(32'h0000_2044, 1'b0, waited);
        drain();
        check_value("fill requests", 1, mem_requests - base);
        base = mem_requests;
        slow_results = 0;
        issue_read(32'h0000_2048, 1'b0, waited);
        drain();
        check_value("hit requests", 0, mem_requests - base);
        check_value("late hit results", 0, slow_results);

        test_name = "uncached";
        base = mem_requests;
        issue_read(32'h0000_3080, 1'b1, waited);
        drain();
        issue_read(32'h0000_3084, 1'b1, waited);
        drain();
        check_value("uncached requests", 2, mem_requests - base);
        base = mem_requests;
        issue_read(32'h0000_3088, 1'b0, waited);
        drain();
        check_value("cached read after uncached", 1, mem_requests - base);

        test_name = "invalidate";
        issue_read(32'h0000_40c8, 1'b0, waited);
        drain();
        base = mem_requests;
        issue_read(32'h0000_40c0, 1'b0, waited);
        drain();
        check_value("hit before invalidate", 0, mem_requests - base);
        invalidate_i = 1'b1;
        @(posedge clk);
        #1 invalidate_i = 1'b0;
        base = mem_requests;
        issue_read(32'h0000_40cc, 1'b0, waited);
        check_value("ack held low for the sweep", 1, waited >= `ICACHE_NSET);
        drain();
        check_value("requests after invalidate", 1, mem_requests - base);

        test_name = "back_to_back";
        for (int i = 0; i < B2B_LINES; i++) begin
            issue_read(32'h0001_0000 + 32'(i * 16), 1'b0, waited);
            drain();
        end
        base = mem_requests;
        slow_results = 0;
        total_wait = 0;
        for (int i = 0; i < B2B_LINES; i++) begin
            issue_read(32'h0001_0004 + 32'(i * 16), 1'b0, waited);
            total_wait += waited;
        end
        drain();
        check_value("hit requests", 0, mem_requests - base);
        check_value("stall cycles", 0, total_wait);
        check_value("late hit results", 0, slow_results);

        // Small address range so hits and evictions both occur
        test_name = "random";
        for (int i = 0; i < RANDOM_READS; i++) begin
            stim_rng = xorshift(stim_rng);
            addr = stim_rng & 32'h0000_0fff;
            uncached = stim_rng[31:29] == 3'b000;
            issue_read(addr, uncached, waited);
        end
        drain();

        if (dut.u_checker.fail_count == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("A protocol assertion failed during the run");
            end_with_failure();
        end
    end

endmodule

// File: icache.f
+incdir+src
src/icache_pkg.sv
src/icache_sram.sv
src/icache_lfsr.sv
src/icache_way.sv
src/icache_ctrl.sv
src/icache.sv
dv/icache_checker.sv
dv/icache_tb.sv

// File: Bender.yml
package:
  name: icache

sources:
  - include_dirs:
      - src
    files:
      - src/icache_pkg.sv
      - src/icache_sram.sv
      - src/icache_lfsr.sv
      - src/icache_way.sv
      - src/icache_ctrl.sv
      - src/icache.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/icache_checker.sv
      - dv/icache_tb.sv
